// ==== source/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    // field overlay of a 32-bit instruction word
    // I-type offset is instr[15:0], J-type target is instr[25:0]
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } instr_fields_t;

    // primary opcodes
    localparam logic [5:0] op_special = 6'b000000;  // R-type, decoded by funct
    localparam logic [5:0] op_regimm  = 6'b000001;  // decoded by rt
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_blez    = 6'b000110;
    localparam logic [5:0] op_bgtz    = 6'b000111;

    // funct codes under op_special
    localparam logic [5:0] fn_jr      = 6'b001000;
    localparam logic [5:0] fn_jalr    = 6'b001001;

    // rt codes under op_regimm
    localparam logic [4:0] rt_bltz    = 5'b00000;
    localparam logic [4:0] rt_bgez    = 5'b00001;
    localparam logic [4:0] rt_bltzal  = 5'b10000;
    localparam logic [4:0] rt_bgezal  = 5'b10001;

    // opcode[5:3] of every load (lb, lh, lwl, lw, lbu, lhu, lwr)
    localparam logic [2:0] load_group = 3'b100;

    // return address register for jal and the regimm linking branches
    localparam logic [4:0] link_reg_ra = 5'd31;

endpackage

`default_nettype wire

// ==== source/pc_unit_pkg.sv ====
`default_nettype none

package pc_unit_pkg;

    // first fetch address after reset, in kseg1 boot rom
    localparam logic [31:0] reset_vector = 32'hBFC00000;

    // core state codes seen by the pc unit
    localparam logic [1:0] st_exec      = 2'd1;  // instruction executes
    localparam logic [1:0] st_writeback = 2'd2;  // load result returns

    // comparison results for the current rs/rt pair
    typedef struct packed {
        logic eq;   // rs == rt
        logic gtz;  // rs > 0, signed
        logic eqz;  // rs == 0
        logic ltz;  // rs < 0, signed
    } cond_flags_t;

    // control transfer info for the current instruction
    typedef struct packed {
        logic        is_jump;    // unconditional j, jal, jr, jalr
        logic        is_branch;  // conditional, needs cond_true
        logic [31:0] dest;       // redirect target after the delay slot
        logic        link_en;    // instruction writes a return address
        logic [4:0]  link_reg;   // register receiving pc + 8
    } cti_info_t;

endpackage

`default_nettype wire

// ==== source/branch_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_compare (
    input  wire logic [5:0]  opcode,
    input  wire logic [4:0]  rt,
    input  wire logic [31:0] rs_data,
    input  wire logic [31:0] rt_data,
    output logic             cond_true
);

    pc_unit_pkg::cond_flags_t flags;

    // flags are computed once and shared by every branch type
    always_comb begin
        flags.eq  = (rs_data == rt_data);
        flags.eqz = (rs_data == 32'd0);
        flags.ltz = rs_data[31];                   // sign bit
        flags.gtz = !rs_data[31] && !flags.eqz;    // positive, nonzero
    end

    always_comb begin
        cond_true = 1'b0;
        case (opcode)
            mips_isa_pkg::op_beq: begin
                cond_true = flags.eq;
            end
            mips_isa_pkg::op_bne: begin
                cond_true = !flags.eq;
            end
            mips_isa_pkg::op_bgtz: begin
                // rt must be zero for a valid encoding
                cond_true = (rt == 5'd0) && flags.gtz;
            end
            mips_isa_pkg::op_blez: begin
                cond_true = (rt == 5'd0) && (flags.eqz || flags.ltz);
            end
            mips_isa_pkg::op_regimm: begin
                case (rt)
                    mips_isa_pkg::rt_bltz,
                    mips_isa_pkg::rt_bltzal: begin
                        cond_true = flags.ltz;
                    end
                    mips_isa_pkg::rt_bgez,
                    mips_isa_pkg::rt_bgezal: begin
                        cond_true = flags.eqz || flags.gtz;
                    end
                    default: begin
                        cond_true = 1'b0;  // unsupported regimm op
                    end
                endcase
            end
            default: begin
                cond_true = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/target_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_decode (
    input  wire mips_isa_pkg::instr_fields_t fields,
    input  wire logic [31:0]                 instr,
    input  wire logic [31:0]                 pc,
    input  wire logic [31:0]                 rs_data,
    output pc_unit_pkg::cti_info_t           cti
);

    logic [31:0] pc_inc;
    logic [31:0] jump_target;
    logic [31:0] branch_target;
    logic        is_jr;
    logic        is_jalr;

    assign pc_inc = pc + 32'd4;

    // region relative, top nibble from the delay slot address
    assign jump_target = {pc_inc[31:28], instr[25:0], 2'b00};

    // word offset, sign extended, relative to the delay slot
    assign branch_target = pc_inc + {{14{instr[15]}}, instr[15:0], 2'b00};

    // register jumps need their unused fields zero
    assign is_jr = (fields.opcode == mips_isa_pkg::op_special)
                && (fields.funct == mips_isa_pkg::fn_jr)
                && (fields.rt == 5'd0)
                && (fields.rd == 5'd0)
                && (fields.sa == 5'd0);

    assign is_jalr = (fields.opcode == mips_isa_pkg::op_special)
                  && (fields.funct == mips_isa_pkg::fn_jalr)
                  && (fields.rt == 5'd0)
                  && (fields.sa == 5'd0);

    always_comb begin
        cti           = '0;
        cti.link_reg  = mips_isa_pkg::link_reg_ra;
        case (fields.opcode)
            mips_isa_pkg::op_j: begin
                cti.is_jump = 1'b1;
                cti.dest    = jump_target;
            end
            mips_isa_pkg::op_jal: begin
                cti.is_jump = 1'b1;
                cti.dest    = jump_target;
                cti.link_en = 1'b1;
            end
            mips_isa_pkg::op_special: begin
                if (is_jr || is_jalr) begin
                    cti.is_jump = 1'b1;
                    cti.dest    = rs_data;
                end
                if (is_jalr) begin
                    cti.link_en  = 1'b1;
                    cti.link_reg = fields.rd;  // jalr links to rd
                end
            end
            mips_isa_pkg::op_beq,
            mips_isa_pkg::op_bne,
            mips_isa_pkg::op_blez,
            mips_isa_pkg::op_bgtz: begin
                cti.is_branch = 1'b1;
                cti.dest      = branch_target;
            end
            mips_isa_pkg::op_regimm: begin
                case (fields.rt)
                    mips_isa_pkg::rt_bltz,
                    mips_isa_pkg::rt_bgez: begin
                        cti.is_branch = 1'b1;
                        cti.dest      = branch_target;
                    end
                    mips_isa_pkg::rt_bltzal,
                    mips_isa_pkg::rt_bgezal: begin
                        cti.is_branch = 1'b1;
                        cti.dest      = branch_target;
                        cti.link_en   = 1'b1;  // links even when not taken
                    end
                    default: begin
                        cti.is_branch = 1'b0;
                    end
                endcase
            end
            default: begin
                cti.is_jump = 1'b0;  // not a control transfer
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/pc_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire pc_unit_pkg::cti_info_t    cti,
    input  wire logic                      cond_true,
    input  wire logic                      load_op,
    input  wire logic [1:0]                state,
    input  wire logic                      waitrequest,
    input  wire logic                      active,
    output logic [31:0]                    pc,
    output logic [31:0]                    regstore
);

    logic [31:0] dest;        // redirect held over the delay slot
    logic        pending;     // redirect waits for the next completion
    logic        enabled;
    logic        exec_state;
    logic        completion;
    logic        accept;
    logic [31:0] pc_inc;

    assign pc_inc   = pc + 32'd4;
    assign regstore = pc + 32'd8;  // return address past the delay slot

    // waitrequest stalls the whole unit
    assign enabled    = active && !waitrequest;
    assign exec_state = (state == pc_unit_pkg::st_exec);

    // loads finish in writeback, everything else in exec
    assign completion = enabled
                     && ((exec_state && !load_op)
                     || (state == pc_unit_pkg::st_writeback));

    assign accept = enabled && exec_state
                 && (cti.is_jump || (cti.is_branch && cond_true));

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= pc_unit_pkg::reset_vector;
            dest    <= 32'd0;
            pending <= 1'b0;
        end else if (accept) begin
            // step into the delay slot, remember where to go after it
            dest    <= cti.dest;
            pending <= 1'b1;
            pc      <= pc_inc;
        end else if (completion) begin
            if (pending) begin
                pc      <= dest;  // delay slot done
                pending <= 1'b0;
            end else begin
                pc <= pc_inc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mips_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pc_unit (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [31:0] instr,
    input  wire logic [31:0] rs_data,
    input  wire logic [31:0] rt_data,
    input  wire logic [1:0]  state,
    input  wire logic        waitrequest,
    input  wire logic        active,
    output logic [31:0]      pc,
    output logic [31:0]      regstore,
    output logic             link_en,
    output logic [4:0]       link_reg
);

    mips_isa_pkg::instr_fields_t fields;
    pc_unit_pkg::cti_info_t      cti;
    logic                        cond_true;
    logic                        load_op;

    assign fields  = mips_isa_pkg::instr_fields_t'(instr);
    assign load_op = (fields.opcode[5:3] == mips_isa_pkg::load_group);

    branch_compare u_branch_compare (
        .opcode    (fields.opcode),
        .rt        (fields.rt),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .cond_true (cond_true)
    );

    target_decode u_target_decode (
        .fields  (fields),
        .instr   (instr),
        .pc      (pc),
        .rs_data (rs_data),
        .cti     (cti)
    );

    pc_sequencer u_pc_sequencer (
        .clk         (clk),
        .reset       (reset),
        .cti         (cti),
        .cond_true   (cond_true),
        .load_op     (load_op),
        .state       (state),
        .waitrequest (waitrequest),
        .active      (active),
        .pc          (pc),
        .regstore    (regstore)
    );

    // link info follows the decoded instruction directly
    assign link_en  = cti.link_en;
    assign link_reg = cti.link_reg;

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int half_period = 2;  // 4 ns clock
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/mips_pc_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pc_unit_tb;

    localparam int num_steps = 600;
    localparam int cycle_limit = num_steps * 4 + 600;  // 4 cycles per step at most

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [1:0]  state;
    logic        waitrequest;
    logic        active;
    logic [31:0] pc;
    logic [31:0] regstore;
    logic        link_en;
    logic [4:0]  link_reg;

    logic [31:0] seed;
    int          cycles;
    logic [31:0] exp_pc;
    logic [31:0] exp_dest;
    logic        exp_pending;
    pc_unit_pkg::cti_info_t ref_cti;
    logic        ref_taken;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    mips_pc_unit uut (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .state       (state),
        .waitrequest (waitrequest),
        .active      (active),
        .pc          (pc),
        .regstore    (regstore),
        .link_en     (link_en),
        .link_reg    (link_reg)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic roll(output logic [31:0] value);
        seed = lcg_step(seed);
        value = seed ^ (seed >> 16);  // low lcg bits repeat with a short period
    endtask

    // expected class, destination and link of an instruction word
    function automatic pc_unit_pkg::cti_info_t expect_cti(input logic [31:0] word,
                                                          input logic [31:0] cur_pc,
                                                          input logic [31:0] rs);
        mips_isa_pkg::instr_fields_t f;
        pc_unit_pkg::cti_info_t c;
        logic [31:0] seq;
        logic        regimm_br;
        f = word;
        seq = cur_pc + 32'd4;
        c = '0;
        c.link_reg = mips_isa_pkg::link_reg_ra;
        regimm_br = (f.opcode == mips_isa_pkg::op_regimm) && (f.rt[3:1] == 3'b000);
        if (f.opcode == mips_isa_pkg::op_j || f.opcode == mips_isa_pkg::op_jal) begin
            c.is_jump = 1'b1;
            c.dest = {seq[31:28], word[25:0], 2'b00};
            c.link_en = (f.opcode == mips_isa_pkg::op_jal);
        end else if (f.opcode == mips_isa_pkg::op_special && f.rt == 5'd0 && f.sa == 5'd0
                     && (f.funct == mips_isa_pkg::fn_jalr
                     || (f.funct == mips_isa_pkg::fn_jr && f.rd == 5'd0))) begin
            c.is_jump = 1'b1;
            c.dest = rs;
            if (f.funct == mips_isa_pkg::fn_jalr) begin
                c.link_en = 1'b1;
                c.link_reg = f.rd;  // jalr names its own link register
            end
        end else if (f.opcode[5:2] == 4'b0001 || regimm_br) begin
            c.is_branch = 1'b1;
            c.dest = seq + {{14{word[15]}}, word[15:0], 2'b00};
            c.link_en = regimm_br && f.rt[4];  // bltzal, bgezal
        end
        return c;
    endfunction

    function automatic logic expect_taken(input logic [31:0] word, input logic [31:0] rs,
                                          input logic [31:0] rt_val);
        mips_isa_pkg::instr_fields_t f;
        f = word;
        case (f.opcode)
            mips_isa_pkg::op_beq:  return rs == rt_val;
            mips_isa_pkg::op_bne:  return rs != rt_val;
            mips_isa_pkg::op_blez: return (f.rt == 5'd0) && ($signed(rs) <= 0);
            mips_isa_pkg::op_bgtz: return (f.rt == 5'd0) && ($signed(rs) > 0);
            mips_isa_pkg::op_regimm: begin
                if (f.rt == mips_isa_pkg::rt_bltz || f.rt == mips_isa_pkg::rt_bltzal)
                    return $signed(rs) < 0;
                if (f.rt == mips_isa_pkg::rt_bgez || f.rt == mips_isa_pkg::rt_bgezal)
                    return $signed(rs) >= 0;
                return 1'b0;
            end
            default: return 1'b0;
        endcase
    endfunction

    always_comb begin
        ref_cti = expect_cti(instr, exp_pc, rs_data);
        ref_taken = expect_taken(instr, rs_data, rt_data);
    end

    // reference pc with the delay slot redirect
    always @(posedge clk) begin
        if (reset) begin
            exp_pc <= pc_unit_pkg::reset_vector;
            exp_dest <= 32'd0;
            exp_pending <= 1'b0;
        end else if (active && !waitrequest) begin
            if (state == pc_unit_pkg::st_exec
                && (ref_cti.is_jump || (ref_cti.is_branch && ref_taken))) begin
                exp_dest <= ref_cti.dest;
                exp_pending <= 1'b1;
                exp_pc <= exp_pc + 32'd4;
            end else if ((state == pc_unit_pkg::st_exec
                          && instr[31:29] != mips_isa_pkg::load_group)
                         || state == pc_unit_pkg::st_writeback) begin
                exp_pc <= exp_pending ? exp_dest : exp_pc + 32'd4;
                exp_pending <= 1'b0;
            end
        end
    end

    task automatic stop_on_mismatch(input string what);
        $display("FAIL at %0t ns: %s", $time, what);
        $display("sim failed");
        $fatal(1, "reference mismatch");
    endtask

    pc_matches: assert property (@(posedge clk) disable iff (reset) pc == exp_pc)
        else stop_on_mismatch($sformatf("pc %h, expected %h", $sampled(pc), $sampled(exp_pc)));
    regstore_matches: assert property (@(posedge clk) disable iff (reset)
                                       regstore == exp_pc + 32'd8)
        else stop_on_mismatch($sformatf("regstore %h with pc %h", $sampled(regstore),
                                        $sampled(exp_pc)));
    link_en_matches: assert property (@(posedge clk) disable iff (reset)
                                      link_en == ref_cti.link_en)
        else stop_on_mismatch($sformatf("link_en %b for instr %h", $sampled(link_en),
                                        $sampled(instr)));
    link_reg_matches: assert property (@(posedge clk) disable iff (reset)
                                       !ref_cti.link_en || link_reg == ref_cti.link_reg)
        else stop_on_mismatch($sformatf("link_reg %0d for instr %h", $sampled(link_reg),
                                        $sampled(instr)));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic drive(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b,
                         input logic [1:0] st, input logic wr, input logic act);
        @(posedge clk);
        instr <= word;
        rs_data <= a;
        rt_data <= b;
        state <= st;
        waitrequest <= wr;
        active <= act;
    endtask

    // mostly control transfers, some loads and plain alu ops
    task automatic pick_instr(output logic [31:0] word, output logic [31:0] a,
                              output logic [31:0] b);
        logic [31:0] r;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        logic [4:0]  code;
        roll(r);
        roll(x);
        roll(y);
        roll(z);
        case (x[20:19])
            2'd0: code = mips_isa_pkg::rt_bltz;
            2'd1: code = mips_isa_pkg::rt_bgez;
            2'd2: code = mips_isa_pkg::rt_bltzal;
            default: code = mips_isa_pkg::rt_bgezal;
        endcase
        if (x[4:2] == 3'd0)
            code = 5'b00010;  // likely variant, not decoded
        case (r[3:0])
            4'd0: word = {mips_isa_pkg::op_j, x[25:0]};
            4'd1: word = {mips_isa_pkg::op_jal, x[25:0]};
            4'd2: word = {mips_isa_pkg::op_beq, x[25:16], y[15:0]};
            4'd3: word = {mips_isa_pkg::op_bne, x[25:16], y[15:0]};
            4'd4: word = {mips_isa_pkg::op_blez, x[25:21], 5'd0, y[15:0]};
            4'd5: word = {mips_isa_pkg::op_bgtz, x[25:21], 5'd0, y[15:0]};
            4'd6, 4'd7: word = {mips_isa_pkg::op_regimm, x[25:21], code, y[15:0]};
            4'd8: word = {mips_isa_pkg::op_special, x[25:21], 15'd0, mips_isa_pkg::fn_jr};
            4'd9: word = {mips_isa_pkg::op_special, x[25:21], 5'd0, x[15:11], 5'd0,
                          mips_isa_pkg::fn_jalr};
            4'd10: word = {mips_isa_pkg::op_special, x[25:21], x[20:16] | 5'd1, x[15:6],
                           x[0] ? mips_isa_pkg::fn_jalr : mips_isa_pkg::fn_jr};
            4'd11, 4'd12: word = {mips_isa_pkg::load_group, y[2:0], x[25:0]};
            default: word = {6'b001001, x[25:0]};  // addiu
        endcase
        a = (y[31:30] == 2'd0) ? 32'd0 : z;
        b = y[29] ? a : {x[7:0], z[23:0]};
    endtask

    task automatic run_step();
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        pick_instr(word, a, b);
        roll(r);
        if (r[2:0] == 3'd0)
            drive(word, a, b, pc_unit_pkg::st_exec, 1'b1, 1'b1);  // memory stall
        else if (r[2:0] == 3'd1)
            drive(word, a, b, pc_unit_pkg::st_exec, 1'b0, 1'b0);  // core idle
        else if (r[2:0] == 3'd2)
            drive(word, a, b, 2'd0, 1'b0, 1'b1);                 // fetch, no step
        drive(word, a, b, pc_unit_pkg::st_exec, 1'b0, 1'b1);
        if (word[31:29] == mips_isa_pkg::load_group) begin
            if (r[3])
                drive(word, a, b, pc_unit_pkg::st_writeback, 1'b1, 1'b1);
            drive(word, a, b, pc_unit_pkg::st_writeback, 1'b0, 1'b1);
        end
    endtask

    initial begin
        instr = 32'd0;
        rs_data = 32'd0;
        rt_data = 32'd0;
        state = 2'd0;
        waitrequest = 1'b0;
        active = 1'b1;
        cycles = 0;
        seed = 32'he5acfa84;
        wait (reset == 1'b0);
        repeat (num_steps) run_step();
        drive(32'd0, 32'd0, 32'd0, 2'd0, 1'b0, 1'b1);
        repeat (2) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_pc_unit.f ====
source/mips_isa_pkg.sv
source/pc_unit_pkg.sv
source/branch_compare.sv
source/target_decode.sv
source/pc_sequencer.sv
source/mips_pc_unit.sv
test/tb_clock_gen.sv
test/mips_pc_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the PC unit testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
obj_dir=obj_dir
binary=mips_pc_unit_sim

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module mips_pc_unit_tb \
    --Mdir "${obj_dir}" -o "${binary}" \
    -f mips_pc_unit.f > "${build_log}" 2>&1
build_status=$?
if [ ${build_status} -ne 0 ]; then
    cat "${build_log}"
    echo "build failed with status ${build_status}"
    exit 1
fi

"./${obj_dir}/${binary}" > "${sim_log}" 2>&1
run_status=$?
cat "${sim_log}"

if grep -q "sim failed" "${sim_log}"; then
    echo "testbench reported failure"
    exit 1
fi
if [ ${run_status} -ne 0 ]; then
    echo "simulation exited with status ${run_status}"
    exit 1
fi
if ! grep -q "sim passed" "${sim_log}"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
